/* sources.f */
+incdir+hdl
hdl/bpu_pkg.sv
hdl/inst_classifier.sv
hdl/direction_predictor.sv
hdl/branch_target_buffer.sv
hdl/return_stack.sv
hdl/bpu_top.sv
tb/tb_clock_gen.sv
tb/bpu_properties.sv
tb/bpu_tb.sv

/* tb/bpu_tb.sv */
`timescale 1ns/10ps
`include "bpu_settings.svh"

module bpu_tb
    import bpu_pkg::*;
();

    localparam int N_RAND      = 24;
    localparam int N_HIST      = 20;
    localparam int STIM_CYCLES = 2 * N_RAND + N_RAND / 2 + N_HIST + 15;
    localparam int TIMEOUT     = 4 * STIM_CYCLES;
    localparam inst_t RET_INST = {12'd0, 5'd1, 3'b000, 5'd0, `BPU_OP_JALR};  // jalr x0, 0(ra)

    typedef struct packed {
        logic  bon;
        logic  res;
        addr_t target;
    } pred_t;

    logic         clk;
    logic         rst;
    addr_t        if_pc_i;
    inst_t        if_inst_i;
    ex_feedback_t ex_fb_i;
    logic         id_push_valid_i;
    addr_t        id_push_addr_i;
    logic         id_stall_i;
    logic         branch_or_not_o;
    addr_t        pdt_pc_o;
    logic         pdt_res_o;
    provider_t    pdt_provider_o;
    hist_t        history_o;

    integer    seed      = 32'hd198bb7d;
    int        errors    = 0;
    int        checks    = 0;
    int        cycle_cnt = 0;
    logic      chk_en    = 1'b0;
    logic      prov_en   = 1'b0;
    pred_t     exp_pred;
    provider_t exp_prov;
    hist_t     model_hist;
    hist_t     h_b;
    addr_t     ras_m [$];            // model stack, back is the top
    logic      btb_v_m   [256];
    btb_tag_t  btb_tag_m [256];
    addr_t     btb_tgt_m [256];
    addr_t     pc_b;
    addr_t     tgt_b;

    tb_clock_gen u_clk (.clk_o(clk), .rst_o(rst));

    bpu_top UUT (.*);

    function automatic addr_t rand_pc();
        logic [31:0] r;
        r = $random(seed);
        return {r[31:2], 2'b00};
    endfunction

    function automatic logic coin();
        logic [31:0] r;
        r = $random(seed);
        return r[0];
    endfunction

    function automatic inst_t alu_inst();
        logic [31:0] r;
        r = $random(seed);
        return {r[31:7], 7'b0010011};   // op-imm, never control flow
    endfunction

    function automatic inst_t branch_inst(logic [31:0] off);
        return {off[12], off[10:5], 5'd2, 5'd1, 3'b000, off[4:1], off[11], `BPU_OP_BRANCH};
    endfunction

    function automatic inst_t jal_inst(logic [31:0] off);
        return {off[20], off[10:1], off[11], off[19:12], 5'd1, `BPU_OP_JAL};
    endfunction

    function automatic logic is_return(inst_t inst);
        return inst[6:0] == `BPU_OP_JALR && (inst[19:15] == 5'd1 || inst[19:15] == 5'd5);
    endfunction

    // expected prediction straight from the fetch rules
    function automatic pred_t expect_target(addr_t pc, inst_t inst, logic dir, logic btb_hit,
                                            addr_t btb_tgt, logic ras_valid, addr_t ras_top);
        addr_t b_off;
        addr_t j_off;
        pred_t p;
        b_off    = {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
        j_off    = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
        p.bon    = inst[6:0] == `BPU_OP_BRANCH || inst[6:0] == `BPU_OP_JAL ||
                   inst[6:0] == `BPU_OP_JALR;
        p.res    = 1'b0;
        p.target = pc + 32'd4;
        if (is_return(inst)) begin
            p.res    = ras_valid;
            p.target = ras_valid ? ras_top : pc + 32'd4;
        end else if (inst[6:0] == `BPU_OP_JAL) begin
            p.res    = 1'b1;
            p.target = btb_hit ? btb_tgt : pc + j_off;
        end else if (inst[6:0] == `BPU_OP_BRANCH && dir) begin
            p.res    = 1'b1;
            p.target = btb_hit ? btb_tgt : pc + b_off;
        end
        return p;
    endfunction

    // one edge later, fold the inputs the DUT just took into the model
    task automatic next_cycle();
        addr_t popped;
        @(posedge clk);
        #2;
        if (ex_fb_i.valid) begin
            model_hist = {model_hist[`BPU_HIST_W-2:0], ex_fb_i.taken};
            if (ex_fb_i.taken) begin
                btb_v_m[ex_fb_i.pc[9:2]]   = 1'b1;
                btb_tag_m[ex_fb_i.pc[9:2]] = ex_fb_i.pc[31:10];
                btb_tgt_m[ex_fb_i.pc[9:2]] = ex_fb_i.target;
            end
            if (ex_fb_i.taken && is_return(ex_fb_i.inst) && !ex_fb_i.stall && ras_m.size() > 0) begin
                popped = ras_m.pop_back();
            end
        end
        if (id_push_valid_i && !id_stall_i && !ex_fb_i.stall && ras_m.size() < `BPU_RAS_DEPTH) begin
            ras_m.push_back(id_push_addr_i);
        end
        ex_fb_i         = '0;
        id_push_valid_i = 1'b0;
        id_stall_i      = 1'b0;
        prov_en         = 1'b0;
    endtask

    task automatic send_feedback(addr_t pc, hist_t h, addr_t tgt, inst_t inst, logic taken,
                                 logic correct, logic stall);
        ex_fb_i = {1'b1, taken, correct, pc, h, tgt, `BPU_PROV_BIM, inst, stall};
    endtask

    task automatic drive_fetch(addr_t pc, inst_t inst, logic dir);
        logic  bypass;
        logic  hit;
        addr_t top;
        bypass    = id_push_valid_i && !id_stall_i && !ex_fb_i.stall;
        hit       = btb_v_m[pc[9:2]] && btb_tag_m[pc[9:2]] == pc[31:10];
        top       = bypass ? id_push_addr_i : (ras_m.size() > 0 ? ras_m[$] : '0);
        if_pc_i   = pc;
        if_inst_i = inst;
        exp_pred  = expect_target(pc, inst, dir, hit, btb_tgt_m[pc[9:2]],
                                  bypass || ras_m.size() > 0, top);
        chk_en    = 1'b1;
    endtask

    initial begin
        if_pc_i         = '0;
        if_inst_i       = 32'h0000_0013;   // nop
        ex_fb_i         = '0;
        id_push_valid_i = 1'b0;
        id_push_addr_i  = '0;
        id_stall_i      = 1'b0;
        model_hist      = '0;
        for (int i = 0; i < 256; i++) begin
            btb_v_m[i] = 1'b0;
        end
        @(negedge rst);

        repeat (N_RAND) begin   // fresh tables predict not taken
            next_cycle();
            drive_fetch(rand_pc(), alu_inst(), 1'b0);
            next_cycle();
            drive_fetch(rand_pc(), branch_inst($random(seed)), 1'b0);
        end
        repeat (N_RAND / 2) begin
            next_cycle();
            drive_fetch(rand_pc(), jal_inst($random(seed)), 1'b0);
        end

        // two taken outcomes, then the same branch is fetched
        pc_b  = rand_pc() | 32'h0001_0000;   // bit 16 falls in the compared tag bits
        tgt_b = rand_pc();
        h_b   = {model_hist[`BPU_HIST_W-3:0], 2'b11};   // history seen at the later fetch
        repeat (2) begin
            next_cycle();
            send_feedback(pc_b, h_b, tgt_b, branch_inst(32'h40), 1'b1, 1'b0, 1'b0);
            drive_fetch(rand_pc(), alu_inst(), 1'b0);
        end
        next_cycle();
        drive_fetch(pc_b, branch_inst(32'h40), 1'b1);
        exp_prov = `BPU_PROV_T1;   // first bimodal miss allocated the long table
        prov_en  = 1'b1;

        repeat (N_HIST) begin
            next_cycle();
            send_feedback(rand_pc(), model_hist, rand_pc(), alu_inst(), coin(), 1'b1, 1'b0);
            drive_fetch(rand_pc(), alu_inst(), 1'b0);
        end

        repeat (3) begin   // each call forwarded to a return fetched alongside
            next_cycle();
            id_push_valid_i = 1'b1;
            id_push_addr_i  = rand_pc();
            drive_fetch(rand_pc(), RET_INST, 1'b0);
        end
        repeat (4) begin   // last one finds the stack empty
            next_cycle();
            send_feedback(rand_pc(), model_hist, rand_pc(), RET_INST, 1'b1, 1'b1, 1'b0);
            drive_fetch(rand_pc(), RET_INST, 1'b0);
        end

        next_cycle();
        id_push_valid_i = 1'b1;
        id_push_addr_i  = rand_pc();
        drive_fetch(rand_pc(), alu_inst(), 1'b0);
        next_cycle();
        id_push_valid_i = 1'b1;
        id_push_addr_i  = rand_pc();
        id_stall_i      = 1'b1;   // decode stall drops this call
        drive_fetch(rand_pc(), alu_inst(), 1'b0);
        next_cycle();
        send_feedback(rand_pc(), model_hist, rand_pc(), RET_INST, 1'b1, 1'b1, 1'b1);
        drive_fetch(rand_pc(), RET_INST, 1'b0);
        next_cycle();
        drive_fetch(rand_pc(), RET_INST, 1'b0);
        next_cycle();
        chk_en = 1'b0;

        $display("checks run: %0d, errors: %0d, property failures: %0d", checks, errors,
                 UUT.u_props.fail_cnt);
        if (errors == 0 && UUT.u_props.fail_cnt == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

    // outputs settle well before the falling edge
    always @(negedge clk) begin
        if (!rst) begin
            assert (history_o == model_hist) else begin
                errors++;
                $display("[FAIL] history_o got %h expected %h", history_o, model_hist);
            end
        end
        if (!rst && chk_en) begin
            checks++;
            assert (branch_or_not_o == exp_pred.bon) else begin
                errors++;
                $display("[FAIL] branch_or_not_o got %h expected %h", branch_or_not_o,
                         exp_pred.bon);
            end
            assert (pdt_res_o == exp_pred.res) else begin
                errors++;
                $display("[FAIL] pdt_res_o got %h expected %h", pdt_res_o, exp_pred.res);
            end
            assert (pdt_pc_o == exp_pred.target) else begin
                errors++;
                $display("[FAIL] pdt_pc_o got %h expected %h", pdt_pc_o, exp_pred.target);
            end
            if (prov_en) begin
                assert (pdt_provider_o == exp_prov) else begin
                    errors++;
                    $display("[FAIL] pdt_provider_o got %h expected %h", pdt_provider_o,
                             exp_prov);
                end
            end
        end
    end

    always @(posedge clk) begin
        if (!rst) begin
            cycle_cnt++;
        end
        if (cycle_cnt > TIMEOUT) begin
            $display("timeout, the run did not end within %0d cycles", TIMEOUT);
            $display("Test failures found");
            $finish;
        end
    end

endmodule

/* tb/bpu_properties.sv */
`timescale 1ns/10ps

module bpu_properties
    import bpu_pkg::*;
(
    input logic  clk,
    input logic  rst,
    input addr_t pc_i,
    input logic  ctrl_i,
    input logic  res_i,
    input addr_t next_pc_i,
    input hist_t hist_i
);

    int fail_cnt = 0;

    // taken only ever comes from a control instruction
    taken_is_control: assert property (@(posedge clk) disable iff (rst) res_i |-> ctrl_i)
        else begin
            fail_cnt++;
            $error("taken prediction on a non-control instruction");
        end

    fall_through_seq: assert property (@(posedge clk) disable iff (rst)
        !res_i |-> next_pc_i == pc_i + 32'd4)
        else begin
            fail_cnt++;
            $error("not-taken prediction does not point at pc+4");
        end

    // history leaves reset cleared
    hist_clear_after_rst: assert property (@(posedge clk) $fell(rst) |-> hist_i == '0)
        else begin
            fail_cnt++;
            $error("history not zero after reset");
        end

endmodule

bind bpu_top bpu_properties u_props (
    .clk(clk), .rst(rst), .pc_i(if_pc_i), .ctrl_i(branch_or_not_o), .res_i(pdt_res_o),
    .next_pc_i(pdt_pc_o), .hist_i(history_o)
);

/* tb/tb_clock_gen.sv */
`timescale 1ns/10ps

module tb_clock_gen (
    output logic clk_o,
    output logic rst_o
);

    initial begin
        clk_o = 1'b0;
        forever #20 clk_o = ~clk_o;   // 40 ns period
    end

    initial begin
        rst_o = 1'b1;
        repeat (10) @(posedge clk_o);
        #2 rst_o = 1'b0;              // release clear of the edge
    end

endmodule

/* hdl/bpu_top.sv */
`timescale 1ns/10ps
`include "bpu_settings.svh"

module bpu_top
    import bpu_pkg::*;
(
    input  logic         clk,
    input  logic         rst,
    input  addr_t        if_pc_i,
    input  inst_t        if_inst_i,
    input  ex_feedback_t ex_fb_i,
    input  logic         id_push_valid_i,
    input  addr_t        id_push_addr_i,
    input  logic         id_stall_i,
    output logic         branch_or_not_o,
    output addr_t        pdt_pc_o,
    output logic         pdt_res_o,
    output provider_t    pdt_provider_o,
    output hist_t        history_o
);

    hist_t       ghr_q;
    inst_class_t if_cls;
    inst_class_t ex_cls;
    logic        dir_taken;
    logic        btb_hit;
    addr_t       btb_target;
    logic        ras_pop;
    logic        ras_push;
    logic        ras_valid;
    addr_t       ras_top;
    addr_t       pc_seq;
    addr_t       jump_target;
    logic        taken;

    // global history, one bit per resolved branch
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            ghr_q <= '0;
        end else if (ex_fb_i.valid) begin
            ghr_q <= {ghr_q[`BPU_HIST_W-2:0], ex_fb_i.taken};
        end
    end

    assign history_o = ghr_q;

    inst_classifier u_if_cls (.inst_i(if_inst_i),    .class_o(if_cls));
    inst_classifier u_ex_cls (.inst_i(ex_fb_i.inst), .class_o(ex_cls));

    direction_predictor u_dir (
        .clk(clk), .rst(rst), .pc_i(if_pc_i), .hist_i(ghr_q), .fb_i(ex_fb_i),
        .taken_o(dir_taken), .provider_o(pdt_provider_o)
    );

    branch_target_buffer u_btb (
        .clk(clk), .rst(rst), .pc_i(if_pc_i), .fb_i(ex_fb_i),
        .hit_o(btb_hit), .target_o(btb_target)
    );

    // stalls hold the stack, pops come from resolved returns only
    assign ras_pop  = ex_fb_i.valid && ex_fb_i.taken && ex_cls.is_ret && !ex_fb_i.stall;
    assign ras_push = id_push_valid_i && !id_stall_i && !ex_fb_i.stall;

    return_stack u_ras (
        .clk(clk), .rst(rst), .push_i(ras_push), .push_addr_i(id_push_addr_i),
        .pop_i(ras_pop), .top_valid_o(ras_valid), .top_addr_o(ras_top)
    );

    assign pc_seq = if_pc_i + addr_t'(4);

    always_comb begin
        taken       = 1'b0;
        jump_target = pc_seq;
        if (if_cls.is_ret) begin
            taken       = ras_valid;    // empty stack falls through
            jump_target = ras_top;
        end else if (if_cls.is_jal) begin
            taken       = 1'b1;
            jump_target = btb_hit ? btb_target : if_pc_i + if_cls.j_offset;
        end else if (if_cls.is_branch) begin
            taken       = dir_taken;
            jump_target = btb_hit ? btb_target : if_pc_i + if_cls.b_offset;
        end
        // indirect jalr other than a return stays not taken
    end

    assign branch_or_not_o = if_cls.is_branch || if_cls.is_jal || if_cls.is_jalr;
    assign pdt_res_o       = taken;
    assign pdt_pc_o        = taken ? jump_target : pc_seq;

endmodule

/* hdl/return_stack.sv */
`timescale 1ns/10ps
`include "bpu_settings.svh"

module return_stack
    import bpu_pkg::*;
(
    input  logic  clk,
    input  logic  rst,
    input  logic  push_i,
    input  addr_t push_addr_i,
    input  logic  pop_i,
    output logic  top_valid_o,
    output addr_t top_addr_o
);

    localparam int DEPTH = `BPU_RAS_DEPTH;
    localparam int AW    = $clog2(DEPTH);

    addr_t    stack_mem [DEPTH];
    ras_ptr_t sp_q;         // next free slot, 0 means empty
    ras_ptr_t sp_pop;
    ras_ptr_t top_ptr;
    logic     do_pop;
    logic     do_push;

    assign do_pop = pop_i && (sp_q != '0);
    assign sp_pop = do_pop ? sp_q - 1'b1 : sp_q;

    // push lands after the pop of the same cycle
    assign do_push = push_i && (sp_pop != ras_ptr_t'(DEPTH));

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            sp_q <= '0;
        end else begin
            sp_q <= do_push ? sp_pop + 1'b1 : sp_pop;
        end
    end

    always_ff @(posedge clk) begin
        if (do_push) begin
            stack_mem[sp_pop[AW-1:0]] <= push_addr_i;
        end
    end

    assign top_ptr = sp_q - 1'b1;

    always_comb begin
        if (push_i) begin
            // call decoded this cycle, forward its return address
            top_valid_o = 1'b1;
            top_addr_o  = push_addr_i;
        end else begin
            top_valid_o = (sp_q != '0);
            top_addr_o  = stack_mem[top_ptr[AW-1:0]];
        end
    end

endmodule

/* hdl/branch_target_buffer.sv */
`timescale 1ns/10ps
`include "bpu_settings.svh"

module branch_target_buffer
    import bpu_pkg::*;
(
    input  logic         clk,
    input  logic         rst,
    input  addr_t        pc_i,
    input  ex_feedback_t fb_i,
    output logic         hit_o,
    output addr_t        target_o
);

    localparam int IW    = `BPU_BTB_IDX_W;
    localparam int TW    = `BPU_BTB_TAG_W;
    localparam int BTB_N = 1 << IW;

    btb_tag_t         tag_mem    [BTB_N];
    addr_t            target_mem [BTB_N];
    logic [BTB_N-1:0] valid_q;

    logic [IW-1:0] rd_idx;
    logic [IW-1:0] wr_idx;
    btb_tag_t      rd_tag;
    btb_tag_t      wr_tag;
    logic          wr_en;

    // word aligned index, upper pc bits as tag
    assign rd_idx = pc_i[IW+1:2];
    assign rd_tag = pc_i[`BPU_XLEN-1:`BPU_XLEN-TW];

    assign wr_idx = fb_i.pc[IW+1:2];
    assign wr_tag = fb_i.pc[`BPU_XLEN-1:`BPU_XLEN-TW];
    assign wr_en  = fb_i.valid && fb_i.taken;   // only taken branches fill

    assign hit_o    = valid_q[rd_idx] && (tag_mem[rd_idx] == rd_tag);
    assign target_o = target_mem[rd_idx];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            valid_q <= '0;
        end else if (wr_en) begin
            valid_q[wr_idx] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en) begin
            tag_mem[wr_idx]    <= wr_tag;
            target_mem[wr_idx] <= fb_i.target;
        end
    end

endmodule

/* hdl/direction_predictor.sv */
`timescale 1ns/10ps
`include "bpu_settings.svh"

module direction_predictor
    import bpu_pkg::*;
(
    input  logic         clk,
    input  logic         rst,
    input  addr_t        pc_i,
    input  hist_t        hist_i,
    input  ex_feedback_t fb_i,
    output logic         taken_o,
    output provider_t    provider_o
);

    localparam int BI     = `BPU_BIM_IDX_W;
    localparam int TI     = `BPU_TAGE_IDX_W;
    localparam int TW     = `BPU_TAG_W;
    localparam int PT     = `BPU_PTAG_W;
    localparam int HW     = `BPU_HIST_W;
    localparam int BIM_N  = 1 << BI;
    localparam int TAGE_N = 1 << TI;

    ctr_t      bim_ctr [BIM_N];
    tage_tag_t t0_tag  [TAGE_N];
    ctr_t      t0_ctr  [TAGE_N];
    tage_tag_t t1_tag  [TAGE_N];
    ctr_t      t1_ctr  [TAGE_N];

    // short history table
    function automatic logic [TI-1:0] t0_index(addr_t pc, hist_t h);
        return pc[TI-1:0] ^ h[TI-1:0];
    endfunction

    // long history table uses the upper half
    function automatic logic [TI-1:0] t1_index(addr_t pc, hist_t h);
        return pc[TI-1:0] ^ h[HW-1:TI];
    endfunction

    function automatic tage_tag_t t0_tag_of(addr_t pc, hist_t h);
        return pc[TI+TW-1:TI] ^ h[HW-1:HW-TW];
    endfunction

    function automatic tage_tag_t t1_tag_of(addr_t pc, hist_t h);
        return pc[TI+TW-1:TI] ^ {{(TW-TI){1'b0}}, h[TI-1:0]};
    endfunction

    function automatic logic ptag_eq(tage_tag_t a, tage_tag_t b);
        return a[TW-1:TW-PT] == b[TW-1:TW-PT];
    endfunction

    function automatic ctr_t sat_step(ctr_t c, logic up);
        if (up && c != 2'b11) begin
            return c + 2'd1;
        end
        if (!up && c != 2'b00) begin
            return c - 2'd1;
        end
        return c;
    endfunction

    logic [BI-1:0] bim_idx;
    logic [BI-1:0] bim_idx_u;
    logic [TI-1:0] t0_idx;
    logic [TI-1:0] t1_idx;
    logic [TI-1:0] t0_idx_u;
    logic [TI-1:0] t1_idx_u;
    tage_tag_t     t0_tag_u;
    tage_tag_t     t1_tag_u;
    logic          t0_hit;
    logic          t1_hit;
    ctr_t          weak_ctr;

    // lookup side
    assign bim_idx = pc_i[BI:1];
    assign t0_idx  = t0_index(pc_i, hist_i);
    assign t1_idx  = t1_index(pc_i, hist_i);
    assign t0_hit  = ptag_eq(t0_tag[t0_idx], t0_tag_of(pc_i, hist_i));
    assign t1_hit  = ptag_eq(t1_tag[t1_idx], t1_tag_of(pc_i, hist_i));

    always_comb begin
        if (t1_hit) begin          // longest history wins
            provider_o = `BPU_PROV_T1;
            taken_o    = t1_ctr[t1_idx][1];
        end else if (t0_hit) begin
            provider_o = `BPU_PROV_T0;
            taken_o    = t0_ctr[t0_idx][1];
        end else begin
            provider_o = `BPU_PROV_BIM;
            taken_o    = bim_ctr[bim_idx][1];
        end
    end

    // update side, rebuilt from the fetch-time pc and history
    assign bim_idx_u = fb_i.pc[BI:1];
    assign t0_idx_u  = t0_index(fb_i.pc, fb_i.history);
    assign t1_idx_u  = t1_index(fb_i.pc, fb_i.history);
    assign t0_tag_u  = t0_tag_of(fb_i.pc, fb_i.history);
    assign t1_tag_u  = t1_tag_of(fb_i.pc, fb_i.history);
    assign weak_ctr  = {fb_i.taken, ~fb_i.taken};   // 10 or 01

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < BIM_N; i++) begin
                bim_ctr[i] <= 2'b01;
            end
            for (int i = 0; i < TAGE_N; i++) begin
                t0_tag[i] <= '0;
                t0_ctr[i] <= 2'b01;
                t1_tag[i] <= '0;
                t1_ctr[i] <= 2'b01;
            end
        end else if (fb_i.valid) begin
            bim_ctr[bim_idx_u] <= sat_step(bim_ctr[bim_idx_u], fb_i.taken);
            case (fb_i.provider)
                `BPU_PROV_T1: begin
                    t1_ctr[t1_idx_u] <= fb_i.pred_correct ?
                                        sat_step(t1_ctr[t1_idx_u], fb_i.taken) :
                                        {2{fb_i.taken}};
                end
                `BPU_PROV_T0: begin
                    t0_ctr[t0_idx_u] <= fb_i.pred_correct ?
                                        sat_step(t0_ctr[t0_idx_u], fb_i.taken) :
                                        {2{fb_i.taken}};
                end
                `BPU_PROV_BIM: begin
                    if (!fb_i.pred_correct) begin
                        // allocate, preferring the long table
                        if (t1_tag[t1_idx_u] != t1_tag_u) begin
                            t1_tag[t1_idx_u] <= t1_tag_u;
                            t1_ctr[t1_idx_u] <= weak_ctr;
                        end else begin
                            t0_tag[t0_idx_u] <= t0_tag_u;
                            t0_ctr[t0_idx_u] <= weak_ctr;
                        end
                    end
                end
                default: ;
            endcase
        end
    end

endmodule

/* hdl/inst_classifier.sv */
`timescale 1ns/10ps
`include "bpu_settings.svh"

module inst_classifier
    import bpu_pkg::*;
(
    input  inst_t       inst_i,
    output inst_class_t class_o
);

    logic [6:0] opcode;
    logic [4:0] rs1;
    logic       is_branch;
    logic       is_jal;
    logic       is_jalr;
    logic       link_src;

    assign opcode = inst_i[6:0];
    assign rs1    = inst_i[19:15];

    assign is_branch = (opcode == `BPU_OP_BRANCH);
    assign is_jal    = (opcode == `BPU_OP_JAL);
    assign is_jalr   = (opcode == `BPU_OP_JALR);

    // ra or t0 as the base register marks a return
    assign link_src = (rs1 == 5'd1) || (rs1 == 5'd5);

    always_comb begin
        class_o.is_branch = is_branch;
        class_o.is_jal    = is_jal;
        class_o.is_jalr   = is_jalr;
        class_o.is_ret    = is_jalr && link_src;

        // imm[12|10:5|4:1|11], bit 0 always zero
        class_o.b_offset = {{(`BPU_XLEN-12){inst_i[31]}},
                            inst_i[7],
                            inst_i[30:25],
                            inst_i[11:8],
                            1'b0};

        // imm[20|10:1|11|19:12]
        class_o.j_offset = {{(`BPU_XLEN-20){inst_i[31]}},
                            inst_i[19:12],
                            inst_i[20],
                            inst_i[30:21],
                            1'b0};
    end

endmodule

/* hdl/bpu_pkg.sv */
`include "bpu_settings.svh"

package bpu_pkg;

    typedef logic [`BPU_XLEN-1:0]      addr_t;
    typedef logic [`BPU_XLEN-1:0]      inst_t;
    typedef logic [`BPU_HIST_W-1:0]    hist_t;
    typedef logic [1:0]                ctr_t;      // 2-bit saturating counter
    typedef logic [`BPU_TAG_W-1:0]     tage_tag_t;
    typedef logic [`BPU_BTB_TAG_W-1:0] btb_tag_t;
    typedef logic [`BPU_RAS_PTR_W-1:0] ras_ptr_t;
    typedef logic [1:0]                provider_t;

    // decoded control-flow info for one instruction
    typedef struct packed {
        logic  is_branch;
        logic  is_jal;
        logic  is_jalr;
        logic  is_ret;     // jalr through x1 or x5
        addr_t b_offset;   // sign-extended B-type immediate
        addr_t j_offset;   // sign-extended J-type immediate
    } inst_class_t;

    // resolved branch info coming back from execute
    typedef struct packed {
        logic      valid;
        logic      taken;
        logic      pred_correct;
        addr_t     pc;
        hist_t     history;   // ghr seen at fetch time
        addr_t     target;
        provider_t provider;  // table that predicted at fetch
        inst_t     inst;
        logic      stall;
    } ex_feedback_t;

endpackage

/* hdl/bpu_settings.svh */
`ifndef BPU_SETTINGS_SVH
`define BPU_SETTINGS_SVH

// datapath widths
`define BPU_XLEN        32
`define BPU_HIST_W      16

// direction predictor geometry
`define BPU_BIM_IDX_W   9
`define BPU_TAGE_IDX_W  8
`define BPU_TAG_W       10
`define BPU_PTAG_W      6    // high tag bits compared on lookup

// target buffer geometry
`define BPU_BTB_IDX_W   8
`define BPU_BTB_TAG_W   22

// return address stack
`define BPU_RAS_DEPTH   64
`define BPU_RAS_PTR_W   7    // one extra bit so a full stack is representable

// rv32 major opcodes
`define BPU_OP_BRANCH   7'b1100011
`define BPU_OP_JAL      7'b1101111
`define BPU_OP_JALR     7'b1100111

// which table supplied the direction
`define BPU_PROV_BIM    2'd0
`define BPU_PROV_T0     2'd1
`define BPU_PROV_T1     2'd2

`endif
